/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module nabp_swap_tb -f nabp_swap.f

run: compile
	./obj_dir/Vnabp_swap_tb > sim.log 2>&1 ; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log ; then echo "simulation failed" ; exit 1 ; fi
	@grep -q "PASS: all tests" sim.log || (echo "no pass line in sim.log" ; exit 1)

clean:
	rm -rf obj_dir sim.log

/* nabp_swap.f */
source/nabp_pkg.sv
source/swap_if.sv
source/angle_regs.sv
source/angle_lut.sv
source/line_swappable.sv
source/swap_control.sv
source/line_accumulator.sv
source/nabp_swap_top.sv
tests/swap_control_properties.sv
tests/nabp_swap_tb.sv

/* source/angle_lut.sv */
`timescale 1ns/100ps
`default_nettype none

module angle_lut (
    input  wire clk,
    input  wire [nabp_pkg::angle_width-1:0] angle,
    output nabp_pkg::scan_mode_t scan_mode,
    output logic [nabp_pkg::s_width-1:0] shift_base
);
    import nabp_pkg::*;

    logic in_x_band;
    logic [angle_width-1:0] angle_mod;

    // x scan near horizontal, y scan around 90 degrees
    assign in_x_band = (angle < angle_width'(angle_45)) ||
                       (angle >= angle_width'(angle_135));

    // linear stand-in for the shift table
    assign angle_mod = angle % angle_width'(angle_45);

    // one cycle from angle to outputs
    always_ff @(posedge clk)
    begin
        if (in_x_band)
            scan_mode <= scan_x;
        else
            scan_mode <= scan_y;
        shift_base <= s_width'(angle_mod);
    end

endmodule

`default_nettype wire

/* source/angle_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module angle_regs (
    input  wire clk,
    input  wire reset_n,
    input  wire psel,
    input  wire penable,
    input  wire pwrite,
    input  wire [nabp_pkg::apb_addr_width-1:0] paddr,
    input  wire [nabp_pkg::apb_data_width-1:0] pwdata,
    output logic [nabp_pkg::apb_data_width-1:0] prdata,
    output logic pready,
    output logic pslverr,
    input  wire next_angle,
    input  wire angle_done,
    output logic start,
    output logic [nabp_pkg::angle_width-1:0] angle
);
    import nabp_pkg::*;

    logic [7:0] done_count;
    logic busy;
    logic wr_access;
    logic wr_angle;
    logic angle_bad;
    logic start_req;

    assign busy = !next_angle;
    assign wr_access = psel && penable && pwrite;
    assign wr_angle = wr_access && (paddr == addr_angle);
    assign angle_bad = pwdata > apb_data_width'(angle_max);
    assign start_req = wr_access && (paddr == addr_ctrl) && pwdata[0];

    // zero wait states
    assign pready = 1'b1;
    assign pslverr = (wr_angle && angle_bad) || (start_req && busy);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            angle <= '0;
            start <= 1'b0;
            done_count <= '0;
        end
        else
        begin
            // refused starts never reach the swap control
            start <= start_req && !busy;
            if (wr_angle && !angle_bad)
                angle <= pwdata[angle_width-1:0];
            if (angle_done)
                done_count <= done_count + 1'b1;
        end
    end

    // read mux
    always_comb
    begin
        prdata = '0;
        case (paddr)
            addr_angle:
                prdata[angle_width-1:0] = angle;
            addr_status:
            begin
                prdata[0] = busy;
                prdata[15:8] = done_count;
            end
            default:
                prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/line_accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

module line_accumulator #(
    parameter int line_size = 8
) (
    input  wire clk,
    input  wire reset_n,
    input  wire pe_kick,
    input  wire pe_en,
    input  wire signed [nabp_pkg::data_width-1:0] pe_sample,
    input  wire [nabp_pkg::part_width-1:0] pe_line,
    output logic signed [nabp_pkg::sum_width-1:0] line_sum,
    output logic [nabp_pkg::part_width-1:0] line_index,
    output logic line_valid
);
    import nabp_pkg::*;

    localparam int cnt_width = $clog2(line_size + 1);

    logic signed [sum_width-1:0] acc;
    logic signed [sum_width-1:0] acc_next;
    logic [cnt_width-1:0] cnt;
    logic last_sample;

    // sign extended sample
    assign acc_next = acc + sum_width'(pe_sample);
    assign last_sample = pe_en && (cnt == cnt_width'(line_size - 1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt <= '0;
            line_valid <= 1'b0;
        end
        else
        begin
            line_valid <= last_sample;
            if (pe_kick)
                cnt <= '0;
            else if (pe_en)
                cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pe_kick)
            acc <= '0;
        else if (pe_en)
            acc <= acc_next;
        // result carries the line it came from
        if (last_sample)
        begin
            line_sum <= acc_next;
            line_index <= pe_line;
        end
    end

endmodule

`default_nettype wire

/* source/line_swappable.sv */
`timescale 1ns/100ps
`default_nettype none

module line_swappable #(
    parameter int line_size = 8
) (
    input  wire clk,
    input  wire reset_n,
    swap_if.swappable sw,
    output logic [nabp_pkg::s_width-1:0] fr_s_val,
    input  wire signed [nabp_pkg::data_width-1:0] fr_val
);
    import nabp_pkg::*;

    localparam int cnt_width = $clog2(line_size + 1);

    logic [cnt_width-1:0] k_cnt;
    logic fetching;
    logic last_addr;
    logic valid_d;
    logic last_d;
    logic swap_q;
    logic next_itr_q;

    assign last_addr = fetching && (k_cnt == cnt_width'(line_size - 1));

    // ram answers one cycle after the address
    assign sw.pe_en = valid_d;
    assign sw.sample = fr_val;
    assign sw.swap = swap_q;
    assign sw.next_itr = next_itr_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fetching <= 1'b0;
            valid_d <= 1'b0;
            last_d <= 1'b0;
            swap_q <= 1'b0;
            next_itr_q <= 1'b1;
        end
        else
        begin
            valid_d <= fetching;
            last_d <= last_addr;
            if (sw.next_itr_ack)
            begin
                fetching <= 1'b1;
                next_itr_q <= 1'b0;
            end
            else if (last_addr)
                fetching <= 1'b0;
            // line fetched, hold swap until acked
            if (valid_d && last_d)
                swap_q <= 1'b1;
            else if (sw.swap_ack)
            begin
                swap_q <= 1'b0;
                next_itr_q <= 1'b1;
            end
        end
    end

    // address walk from the line base, wraps at s_width
    always_ff @(posedge clk)
    begin
        if (sw.next_itr_ack)
        begin
            fr_s_val <= sw.line_base;
            k_cnt <= '0;
        end
        else if (fetching)
        begin
            fr_s_val <= fr_s_val + 1'b1;
            k_cnt <= k_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/nabp_pkg.sv */
`default_nettype none

package nabp_pkg;

    // datapath widths
    localparam int angle_width = 8;
    localparam int data_width = 12;
    localparam int s_width = 8;
    localparam int sum_width = 20;
    localparam int part_width = 4;

    // angles in degrees, valid range 0..angle_max
    localparam int angle_max = 179;
    localparam int angle_45 = 45;
    localparam int angle_135 = 135;

    // apb register map, one word each
    localparam int apb_addr_width = 4;
    localparam int apb_data_width = 32;
    localparam logic [apb_addr_width-1:0] addr_angle = 4'h0;
    localparam logic [apb_addr_width-1:0] addr_ctrl = 4'h4;
    localparam logic [apb_addr_width-1:0] addr_status = 4'h8;

    typedef enum logic {
        scan_x = 1'b0,
        scan_y = 1'b1
    } scan_mode_t;

    typedef enum logic [2:0] {
        ready_s,
        setup_s,
        fill_s,
        fill_and_shift_s,
        shift_s
    } swap_state_t;

endpackage

`default_nettype wire

/* source/nabp_swap_top.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_swap_top #(
    parameter int line_size = 8,
    parameter int partition_size = 4
) (
    input  wire clk,
    input  wire reset_n,
    input  wire psel,
    input  wire penable,
    input  wire pwrite,
    input  wire [nabp_pkg::apb_addr_width-1:0] paddr,
    input  wire [nabp_pkg::apb_data_width-1:0] pwdata,
    output wire [nabp_pkg::apb_data_width-1:0] prdata,
    output wire pready,
    output wire pslverr,
    output wire [nabp_pkg::s_width-1:0] fr0_s_val,
    output wire [nabp_pkg::s_width-1:0] fr1_s_val,
    input  wire signed [nabp_pkg::data_width-1:0] fr0_val,
    input  wire signed [nabp_pkg::data_width-1:0] fr1_val,
    output wire signed [nabp_pkg::sum_width-1:0] line_sum,
    output wire [nabp_pkg::part_width-1:0] line_index,
    output wire line_valid,
    output wire angle_done
);
    import nabp_pkg::*;

    logic start;
    logic [angle_width-1:0] angle;
    logic next_angle;
    logic pe_kick;
    logic pe_en;
    logic signed [data_width-1:0] pe_sample;
    logic [part_width-1:0] pe_line;

    angle_regs angle_regs_i (
        .clk(clk),
        .reset_n(reset_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .next_angle(next_angle),
        .angle_done(angle_done),
        .start(start),
        .angle(angle)
    );

    // scan mode would feed the mapper stage, not built here
    swap_control #(
        .line_size(line_size),
        .partition_size(partition_size)
    ) swap_control_i (
        .clk(clk),
        .reset_n(reset_n),
        .start(start),
        .angle(angle),
        .next_angle(next_angle),
        .angle_done(angle_done),
        .fr0_s_val(fr0_s_val),
        .fr1_s_val(fr1_s_val),
        .fr0_val(fr0_val),
        .fr1_val(fr1_val),
        .pe_kick(pe_kick),
        .pe_en(pe_en),
        .pe_sample(pe_sample),
        .pe_line(pe_line),
        .pe_scan_mode()
    );

    line_accumulator #(.line_size(line_size)) line_accumulator_i (
        .clk(clk),
        .reset_n(reset_n),
        .pe_kick(pe_kick),
        .pe_en(pe_en),
        .pe_sample(pe_sample),
        .pe_line(pe_line),
        .line_sum(line_sum),
        .line_index(line_index),
        .line_valid(line_valid)
    );

endmodule

`default_nettype wire

/* source/swap_control.sv */
`timescale 1ns/100ps
`default_nettype none

module swap_control #(
    parameter int line_size = 8,
    parameter int partition_size = 4
) (
    input  wire clk,
    input  wire reset_n,
    input  wire start,
    input  wire [nabp_pkg::angle_width-1:0] angle,
    output logic next_angle,
    output logic angle_done,
    output logic [nabp_pkg::s_width-1:0] fr0_s_val,
    output logic [nabp_pkg::s_width-1:0] fr1_s_val,
    input  wire signed [nabp_pkg::data_width-1:0] fr0_val,
    input  wire signed [nabp_pkg::data_width-1:0] fr1_val,
    output logic pe_kick,
    output logic pe_en,
    output logic signed [nabp_pkg::data_width-1:0] pe_sample,
    output logic [nabp_pkg::part_width-1:0] pe_line,
    output nabp_pkg::scan_mode_t pe_scan_mode
);
    import nabp_pkg::*;

    swap_state_t state;
    swap_state_t next_state;

    // lines issued so far in this angle
    logic [part_width-1:0] line_itr;
    // base of the next line to issue
    logic [s_width-1:0] next_base;
    logic [s_width-1:0] shift_base_q;
    logic [s_width-1:0] base_step;
    logic sw_sel;

    scan_mode_t lut_scan_mode;
    logic [s_width-1:0] lut_shift_base;

    logic act_swap;
    logic act_next_itr;
    logic oth_next_itr;
    logic swap_ack;
    logic has_more;
    logic first_ack;
    logic oth_ack;

    swap_if sw0 ();
    swap_if sw1 ();

    angle_lut angle_lut_i (
        .clk(clk),
        .angle(angle),
        .scan_mode(lut_scan_mode),
        .shift_base(lut_shift_base)
    );

    line_swappable #(.line_size(line_size)) sw0_i (
        .clk(clk),
        .reset_n(reset_n),
        .sw(sw0),
        .fr_s_val(fr0_s_val),
        .fr_val(fr0_val)
    );

    line_swappable #(.line_size(line_size)) sw1_i (
        .clk(clk),
        .reset_n(reset_n),
        .sw(sw1),
        .fr_s_val(fr1_s_val),
        .fr_val(fr1_val)
    );

    // active swappable is the one streaming to the pe
    assign act_swap = sw_sel ? sw1.swap : sw0.swap;
    assign act_next_itr = sw_sel ? sw1.next_itr : sw0.next_itr;
    assign oth_next_itr = sw_sel ? sw0.next_itr : sw1.next_itr;
    assign has_more = (line_itr != part_width'(partition_size));

    // swap needs the active done and the other one idle
    assign swap_ack = (state == fill_s || state == fill_and_shift_s) &&
                      act_swap && oth_next_itr;
    assign first_ack = (state == setup_s) && act_next_itr;
    assign oth_ack = swap_ack && has_more;

    assign sw0.swap_ack = swap_ack && !sw_sel;
    assign sw1.swap_ack = swap_ack && sw_sel;
    assign sw0.next_itr_ack = sw_sel ? oth_ack : first_ack;
    assign sw1.next_itr_ack = sw_sel ? first_ack : oth_ack;
    assign sw0.line_base = next_base;
    assign sw1.line_base = next_base;

    assign next_angle = (state == ready_s);
    assign pe_kick = first_ack || oth_ack;
    assign pe_en = sw_sel ? sw1.pe_en : sw0.pe_en;
    assign pe_sample = sw_sel ? sw1.sample : sw0.sample;
    // lut output is fresh in setup, latched copy afterwards
    assign base_step = (state == setup_s) ? lut_shift_base : shift_base_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
            sw_sel <= 1'b0;
            angle_done <= 1'b0;
        end
        else
        begin
            state <= next_state;
            angle_done <= swap_ack && !has_more;
            if (swap_ack)
                sw_sel <= !sw_sel;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (start)
                    next_state = setup_s;
            setup_s:
                if (first_ack)
                    next_state = fill_s;
            fill_s:
                if (swap_ack)
                begin
                    if (has_more)
                        next_state = fill_and_shift_s;
                    else
                        next_state = shift_s;
                end
            fill_and_shift_s:
                if (swap_ack && !has_more)
                    next_state = shift_s;
            shift_s:
                // wait for the last line's swappable to go idle
                if (oth_next_itr)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // line n starts at n times the shift base
    always_ff @(posedge clk)
    begin
        if (state == ready_s)
        begin
            line_itr <= '0;
            next_base <= '0;
        end
        else if (pe_kick)
        begin
            line_itr <= line_itr + 1'b1;
            next_base <= next_base + base_step;
        end
        if (pe_kick)
            pe_line <= line_itr;
        if (state == setup_s)
        begin
            shift_base_q <= lut_shift_base;
            pe_scan_mode <= lut_scan_mode;
        end
    end

endmodule

`default_nettype wire

/* source/swap_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface swap_if;
    import nabp_pkg::*;

    // control to swappable
    logic [s_width-1:0] line_base;
    logic swap_ack;
    logic next_itr_ack;

    // swappable to control
    logic swap;
    logic next_itr;
    logic pe_en;
    logic signed [data_width-1:0] sample;

    modport control (
        output line_base, swap_ack, next_itr_ack,
        input  swap, next_itr, pe_en, sample
    );

    modport swappable (
        input  line_base, swap_ack, next_itr_ack,
        output swap, next_itr, pe_en, sample
    );

endinterface

`default_nettype wire

/* tests/nabp_swap_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_swap_tb;
    import nabp_pkg::*;

    localparam int line_size = 8;
    localparam int partition_size = 4;
    localparam int num_rows = 8;
    localparam int wait_limit = 300;

    // angle, expect pslverr on the angle write, try a second start while busy
    typedef struct packed {
        int angle;
        logic exp_err;
        logic early;
    } row_t;

    row_t rows [num_rows] = '{
        '{10, 1'b0, 1'b0},
        '{44, 1'b0, 1'b1},
        '{45, 1'b0, 1'b0},
        '{90, 1'b0, 1'b0},
        '{200, 1'b1, 1'b0},
        '{134, 1'b0, 1'b0},
        '{135, 1'b0, 1'b1},
        '{179, 1'b0, 1'b0}
    };

    logic clk;
    logic reset_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    wire [apb_data_width-1:0] prdata;
    wire pready;
    wire pslverr;
    wire [s_width-1:0] fr0_s_val;
    wire [s_width-1:0] fr1_s_val;
    logic signed [data_width-1:0] fr0_val;
    logic signed [data_width-1:0] fr1_val;
    wire signed [sum_width-1:0] line_sum;
    wire [part_width-1:0] line_index;
    wire line_valid;
    wire angle_done;

    logic signed [data_width-1:0] ram [0:255];
    logic [s_width-1:0] prev_addr0;
    logic [s_width-1:0] prev_addr1;

    // observed results
    logic signed [sum_width-1:0] sum_q [$];
    logic [part_width-1:0] idx_q [$];
    int cycle = 0;
    int last_line_cycle = 0;
    int done_cycle = 0;
    int done_total = 0;

    nabp_swap_top #(
        .line_size(line_size),
        .partition_size(partition_size)
    ) nabp_swap_top_i (
        .clk(clk),
        .reset_n(reset_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .fr0_s_val(fr0_s_val),
        .fr1_s_val(fr1_s_val),
        .fr0_val(fr0_val),
        .fr1_val(fr1_val),
        .line_sum(line_sum),
        .line_index(line_index),
        .line_valid(line_valid),
        .angle_done(angle_done)
    );

    always #2 clk = !clk;

    // filtered projection ram, data one cycle after the address
    always @(posedge clk)
    begin
        #1;
        fr0_val <= ram[prev_addr0];
        fr1_val <= ram[prev_addr1];
        prev_addr0 <= fr0_s_val;
        prev_addr1 <= fr1_s_val;
    end

    // output monitor, sampled mid cycle
    always @(posedge clk)
    begin
        #2;
        cycle = cycle + 1;
        if (reset_n === 1'b1 && line_valid === 1'b1)
        begin
            sum_q.push_back(line_sum);
            idx_q.push_back(line_index);
            last_line_cycle = cycle;
        end
        if (reset_n === 1'b1 && angle_done === 1'b1)
        begin
            done_total = done_total + 1;
            done_cycle = cycle;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sum(input logic signed [sum_width-1:0] got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    task automatic check_index(input logic [part_width-1:0] got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    task automatic check_apb(input logic [apb_data_width-1:0] got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_scan(input scan_mode_t got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    task automatic check_count(input int got, exp, input string what);
        if (got != exp)
            fail_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    // one apb transfer, setup then access phase
    task automatic bus_transfer(input logic write, input logic [apb_addr_width-1:0] addr,
                                input logic [apb_data_width-1:0] data,
                                output logic [apb_data_width-1:0] rdata, output logic err);
        int cycles;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        cycles = 0;
        while (pready !== 1'b1)
        begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > wait_limit)
                fail_run("timed out waiting for pready");
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input logic [apb_addr_width-1:0] addr,
                             input logic [apb_data_width-1:0] data, output logic err);
        logic [apb_data_width-1:0] unused_rdata;
        bus_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic read_reg(input logic [apb_addr_width-1:0] addr,
                            output logic [apb_data_width-1:0] rdata, output logic err);
        bus_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic wait_angle_done(input int done_before);
        int cycles;
        cycles = 0;
        while (done_total == done_before)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit)
                fail_run("timed out waiting for angle_done");
        end
    endtask

    // poll status until the busy bit drops
    task automatic wait_idle(output logic [apb_data_width-1:0] status);
        logic err;
        int polls;
        polls = 0;
        read_reg(addr_status, status, err);
        while (status[0] !== 1'b0)
        begin
            polls++;
            if (polls > wait_limit)
                fail_run("timed out waiting for the engine to go idle");
            read_reg(addr_status, status, err);
        end
    endtask

    // line n starts at n times (angle mod 45), addresses wrap at 256
    function automatic logic signed [sum_width-1:0] expected_line_sum(input int ang, input int n);
        logic signed [sum_width-1:0] acc;
        int base;
        acc = '0;
        base = n * (ang % angle_45);
        for (int k = 0; k < line_size; k++)
            acc = acc + sum_width'(ram[s_width'(base + k)]);
        return acc;
    endfunction

    function automatic scan_mode_t expected_scan(input int ang);
        if (ang < angle_45 || ang >= angle_135)
            return scan_x;
        else
            return scan_y;
    endfunction

    initial
    begin
        logic err;
        logic [apb_data_width-1:0] rdata;
        int expected_angle;
        int runs;
        int done_before;
        clk = 1'b0;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        fr0_val = '0;
        fr1_val = '0;
        prev_addr0 = '0;
        prev_addr1 = '0;
        void'($urandom(24));
        for (int i = 0; i < 256; i++)
            ram[s_width'(i)] = data_width'($urandom());
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // idle after reset
        read_reg(addr_status, rdata, err);
        check_flag(err, 1'b0, "pslverr on status read");
        check_apb(rdata, '0, "status after reset");
        repeat (20) @(posedge clk);
        check_count(sum_q.size(), 0, "lines without a start");

        expected_angle = 0;
        runs = 0;
        for (int r = 0; r < num_rows; r++)
        begin
            write_reg(addr_angle, apb_data_width'(rows[r].angle), err);
            check_flag(err, rows[r].exp_err, "pslverr on angle write");
            if (!rows[r].exp_err)
                expected_angle = rows[r].angle;
            read_reg(addr_angle, rdata, err);
            check_apb(rdata, apb_data_width'(expected_angle), "angle register");

            sum_q.delete();
            idx_q.delete();
            done_before = done_total;
            write_reg(addr_ctrl, 32'h1, err);
            check_flag(err, 1'b0, "pslverr on start");
            runs++;
            if (rows[r].early)
            begin
                write_reg(addr_ctrl, 32'h1, err);
                check_flag(err, 1'b1, "pslverr on start while busy");
            end
            wait_angle_done(done_before);
            wait_idle(rdata);
            check_apb(rdata, apb_data_width'(runs << 8), "status after angle");

            check_count(sum_q.size(), partition_size, "lines per angle");
            for (int n = 0; n < partition_size; n++)
            begin
                check_index(idx_q[n], part_width'(n), "line index");
                check_sum(sum_q[n], expected_line_sum(expected_angle, n), "line sum");
            end
            check_count(done_cycle, last_line_cycle + 1, "angle_done cycle");
            check_scan(nabp_swap_top_i.swap_control_i.pe_scan_mode,
                       expected_scan(expected_angle), "scan mode");
        end

        if (nabp_swap_top_i.swap_control_i.swap_control_props_i.error_count == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
            fail_run("concurrent assertions in swap_control failed");
    end

endmodule

`default_nettype wire

/* tests/swap_control_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module swap_control_properties (
    input  wire clk,
    input  wire reset_n,
    input  wire sw0_swap_ack,
    input  wire sw1_swap_ack,
    input  wire sw0_pe_en,
    input  wire sw1_pe_en,
    input  wire sw_sel,
    input  wire angle_done
);

    // assertion failures so far
    int error_count = 0;

    // samples come only from the active swappable
    idle_side_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        !(sw_sel ? sw0_pe_en : sw1_pe_en))
    else
    begin
        $error("inactive swappable streamed a sample");
        error_count++;
    end

    // active side toggles only on a swap
    sel_on_ack: assert property (@(posedge clk) disable iff (!reset_n)
        !(sw0_swap_ack || sw1_swap_ack) |=> $stable(sw_sel))
    else
    begin
        $error("sw_sel changed without swap_ack");
        error_count++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        angle_done |=> !angle_done)
    else
    begin
        $error("angle_done high for more than one cycle");
        error_count++;
    end

endmodule

bind swap_control swap_control_properties swap_control_props_i (
    .clk(clk),
    .reset_n(reset_n),
    .sw0_swap_ack(sw0.swap_ack),
    .sw1_swap_ack(sw1.swap_ack),
    .sw0_pe_en(sw0.pe_en),
    .sw1_pe_en(sw1.pe_en),
    .sw_sel(sw_sel),
    .angle_done(angle_done)
);

`default_nettype wire
